//--- compile.f
+incdir+verilog
verilog/mul_pkg.sv
verilog/array_mult8.sv
verilog/cla_adder32.sv
verilog/mul_request_decode.sv
verilog/partial_product_stage.sv
verilog/product_result.sv
verilog/mul16_unit.sv
sim/clock_gen.sv
sim/mul16_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the multiplier testbench with Verilator.
# The exit status is the simulator's own: zero on pass, nonzero on $fatal.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module mul16_tb \
  -f compile.f \
  -o sim_mul16

./obj_dir/sim_mul16

//--- sim/clock_gen.sv
`timescale 1ns/100ps

module clock_gen #(
  parameter int PERIOD     = 8,
  parameter int RST_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  // Release lands on a falling edge
  initial begin
    rst_n = 1'b0;
    #(PERIOD*RST_CYCLES);
    rst_n = 1'b1;
  end

endmodule

//--- sim/mul16_tb.sv
`timescale 1ns/100ps
`include "mul_defs.svh"

module mul16_tb
  import mul_pkg::*;
();

  localparam int MAX_TESTS  = 32;
  localparam int RAND_TESTS = 200;
  localparam int ENTRY_W    = 2*`MUL_OPND_W + `MUL_PROD_W;

  logic          clk;
  logic          rst_n;
  logic          req;
  operand_pair_t operands;
  logic          ack;
  prod_t         product;

  logic [ENTRY_W-1:0] test_mem [0:MAX_TESTS-1];
  int                 num_tests;
  int                 cycle_count = 0;
  int                 cycle_limit = 100;
  integer             seed;

  clock_gen u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mul16_unit UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .operands (operands),
    .ack      (ack),
    .product  (product)
  );

  // b is zero here, so the product field can never be a valid entry
  function automatic logic [ENTRY_W-1:0] fill_word(input int addr);
    return {16'(addr), 16'h0000, 32'hffff_ffff};
  endfunction

  task automatic check_product(input prod_t expected, input prod_t actual);
    if (actual !== expected) begin
      $display("Error at time %0t: product expected %h, actual %h", $time, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "product mismatch");
    end
  endtask

  task automatic check_ack(input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error at time %0t: ack expected %b, actual %b", $time, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "ack mismatch");
    end
  endtask

  // One full four-phase transfer, entered on a falling edge with ack low
  task automatic run_request(input opnd_t a, input opnd_t b, input prod_t expected,
                             input int hold);
    operands.a = a;
    operands.b = b;
    req        = 1'b1;
    // First rising edge samples req, ack follows four edges later
    repeat (4) begin
      @(negedge clk);
      check_ack(1'b0, ack);
    end
    @(negedge clk);
    check_ack(1'b1, ack);
    check_product(expected, product);
    repeat (hold) begin
      @(negedge clk);
      check_ack(1'b1, ack);
      check_product(expected, product);
    end
    req      = 1'b0;
    operands = '0;
    @(negedge clk);
    check_ack(1'b1, ack);
    check_product(expected, product);
    @(negedge clk);
    check_ack(1'b0, ack);
    check_product(expected, product);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run still going after %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end
  end

  initial begin
    logic [ENTRY_W-1:0] entry;
    logic [31:0]        rnd;
    opnd_t              ra;
    opnd_t              rb;
    req      = 1'b0;
    operands = '0;
    seed     = 59986;
    for (int i = 0; i < MAX_TESTS; i++) begin
      test_mem[i] = fill_word(i);
    end
    $readmemh("sim/mul16_tests.txt", test_mem);
    num_tests = 0;
    while (num_tests < MAX_TESTS && test_mem[num_tests] !== fill_word(num_tests)) begin
      num_tests++;
    end
    cycle_limit = 20*(num_tests + RAND_TESTS) + 100;
    if (num_tests == 0) begin
      $display("No test vectors were read from sim/mul16_tests.txt");
      $display("ERRORS FOUND");
      $fatal(1, "empty test file");
    end

    wait (rst_n === 1'b1);
    @(posedge clk);
    @(negedge clk);
    check_ack(1'b0, ack);
    check_product('0, product);

    // Directed entries, some with req held past ack
    for (int i = 0; i < num_tests; i++) begin
      entry = test_mem[i];
      run_request(entry[63:48], entry[47:32], entry[31:0], i % 3);
    end

    for (int n = 0; n < RAND_TESTS; n++) begin
      rnd = $random(seed);
      ra  = rnd[15:0];
      rb  = rnd[31:16];
      run_request(ra, rb, {16'h0000, ra} * {16'h0000, rb}, n % 2);
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- sim/mul16_tests.txt
// One 64-bit hex word per line: a (16 bits), b (16 bits), expected product (32 bits)
// Zero, one and maximum operands first, then carries through the byte sums
0000_0000_0000_0000
0000_ffff_0000_0000
ffff_0000_0000_0000
0001_0001_0000_0001
0001_ffff_0000_ffff
ffff_0001_0000_ffff
ffff_ffff_fffe_0001
fffe_ffff_fffd_0002
7fff_7fff_3fff_0001
8000_8000_4000_0000
8000_0002_0001_0000
0100_0100_0001_0000
0101_0101_0001_0201
00ff_00ff_0000_fe01
00ff_0101_0000_ffff
00ff_ff00_00fe_0100
ff00_00ff_00fe_0100
ff00_ff00_fe01_0000
00ff_ffff_00fe_ff01
ff01_ff01_fe02_fe01
1234_5678_0626_0060
abcd_ef01_a065_0ecd

//--- verilog/array_mult8.sv
`timescale 1ns/100ps
`include "mul_defs.svh"

module array_mult8 (
  input  logic [`MUL_HALF_W-1:0]   a,
  input  logic [`MUL_HALF_W-1:0]   b,
  output logic [2*`MUL_HALF_W-1:0] p
);

  localparam int W = `MUL_HALF_W;

  // AND term t[i][j] has weight i+j
  logic [W-1:0][W-1:0] t;
  // Row sums, top column tied low
  logic [W-1:0][W:0]   s;
  logic [W-1:1][W-1:0] c;
  // Final carry row
  logic [W-1:0]        r;

  genvar i, j;
  generate
    for (i = 0; i < W; i++) begin : g_and_row
      assign t[i]    = a & {W{b[i]}};
      assign s[i][W] = 1'b0;
      assign p[i]    = s[i][0];
    end

    assign s[0][W-1:0] = t[0];

    for (i = 1; i < W; i++) begin : g_add_row
      for (j = 0; j < W; j++) begin : g_cell
        if (i == 1) begin : g_half
          assign s[i][j] = t[i][j] ^ s[i-1][j+1];
          assign c[i][j] = t[i][j] & s[i-1][j+1];
        end else begin : g_full
          assign s[i][j] = t[i][j] ^ s[i-1][j+1] ^ c[i-1][j];
          assign c[i][j] = (t[i][j] & s[i-1][j+1]) |
                           (c[i-1][j] & (t[i][j] ^ s[i-1][j+1]));
        end
      end
    end

    // Merge last sum and carry vectors into the upper byte
    assign r[0] = 1'b0;
    for (j = 0; j < W; j++) begin : g_final
      assign p[W+j] = s[W-1][j+1] ^ c[W-1][j] ^ r[j];
      if (j < W-1) begin : g_carry
        assign r[j+1] = (s[W-1][j+1] & c[W-1][j]) |
                        (r[j] & (s[W-1][j+1] ^ c[W-1][j]));
      end
    end
  endgenerate

endmodule

//--- verilog/cla_adder32.sv
`timescale 1ns/100ps
`include "mul_defs.svh"

module cla_adder32 (
  input  logic [`MUL_PROD_W-1:0] a,
  input  logic [`MUL_PROD_W-1:0] b,
  output logic [`MUL_PROD_W-1:0] sum
);

  localparam int GW = `CLA_GROUP_W;
  localparam int NG = `MUL_PROD_W / `CLA_GROUP_W;

  logic [`MUL_PROD_W-1:0] p;
  logic [`MUL_PROD_W-1:0] g;
  // Top group drives no carry, so no group terms for it
  logic [NG-2:0]          grp_p;
  logic [NG-2:0]          grp_g;
  logic [NG-1:0]          grp_c;

  assign p = a ^ b;
  assign g = a & b;

  always_comb begin
    logic term;
    for (int k = 0; k < NG-1; k++) begin
      grp_p[k] = &p[k*GW +: GW];
      grp_g[k] = 1'b0;
      for (int i = 0; i < GW; i++) begin
        term = g[k*GW+i];
        for (int n = i+1; n < GW; n++) begin
          term = term & p[k*GW+n];
        end
        grp_g[k] = grp_g[k] | term;
      end
    end
  end

  // Second-level lookahead with carry-in of zero
  always_comb begin
    logic term;
    logic acc;
    grp_c[0] = 1'b0;
    for (int k = 1; k < NG; k++) begin
      acc = 1'b0;
      for (int m = 0; m < k; m++) begin
        term = grp_g[m];
        for (int n = m+1; n < k; n++) begin
          term = term & grp_p[n];
        end
        acc = acc | term;
      end
      grp_c[k] = acc;
    end
  end

  genvar gi;
  generate
    for (gi = 0; gi < NG; gi++) begin : g_grp
      cla_group4 u_grp (
        .p   (p[gi*GW +: GW]),
        .g   (g[gi*GW +: GW]),
        .cin (grp_c[gi]),
        .sum (sum[gi*GW +: GW])
      );
    end
  endgenerate

endmodule

module cla_group4 (
  input  logic [`CLA_GROUP_W-1:0] p,
  input  logic [`CLA_GROUP_W-1:0] g,
  input  logic                    cin,
  output logic [`CLA_GROUP_W-1:0] sum
);

  logic [`CLA_GROUP_W-1:0] c;

  // Every carry expanded straight from cin
  always_comb begin
    logic term;
    logic acc;
    c[0] = cin;
    for (int k = 1; k < `CLA_GROUP_W; k++) begin
      acc = cin;
      for (int n = 0; n < k; n++) begin
        acc = acc & p[n];
      end
      for (int m = 0; m < k; m++) begin
        term = g[m];
        for (int n = m+1; n < k; n++) begin
          term = term & p[n];
        end
        acc = acc | term;
      end
      c[k] = acc;
    end
  end

  assign sum = p ^ c;

endmodule

//--- verilog/mul16_unit.sv
`timescale 1ns/100ps

module mul16_unit
  import mul_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          req,
  input  operand_pair_t operands,
  output logic          ack,
  output prod_t         product
);

  logic        issue;
  half_split_t halves;
  logic        pp_valid;
  pp_set_t     pps;
  logic        done;

  mul_request_decode u_request (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .operands (operands),
    .done     (done),
    .ack      (ack),
    .issue    (issue),
    .halves   (halves)
  );

  partial_product_stage u_pp (
    .clk      (clk),
    .rst_n    (rst_n),
    .issue    (issue),
    .halves   (halves),
    .pp_valid (pp_valid),
    .pps      (pps)
  );

  product_result u_result (
    .clk      (clk),
    .rst_n    (rst_n),
    .pp_valid (pp_valid),
    .pps      (pps),
    .done     (done),
    .product  (product)
  );

endmodule

//--- verilog/mul_defs.svh
`ifndef MUL_DEFS_SVH
`define MUL_DEFS_SVH

// Operand width seen by the requester
`define MUL_OPND_W 16

// Each operand splits into two of these
`define MUL_HALF_W 8

// Full product width
`define MUL_PROD_W 32

// Bits per carry-lookahead group
`define CLA_GROUP_W 4

`endif

//--- verilog/mul_pkg.sv
`include "mul_defs.svh"

package mul_pkg;

  typedef logic [`MUL_OPND_W-1:0]   opnd_t;
  typedef logic [`MUL_HALF_W-1:0]   half_t;
  typedef logic [2*`MUL_HALF_W-1:0] pp_t;
  typedef logic [`MUL_PROD_W-1:0]   prod_t;

  typedef struct packed {
    opnd_t a;
    opnd_t b;
  } operand_pair_t;

  typedef struct packed {
    half_t a_hi;
    half_t a_lo;
    half_t b_hi;
    half_t b_lo;
  } half_split_t;

  // Field names give the a half first, then the b half
  typedef struct packed {
    pp_t ll;
    pp_t lh;
    pp_t hl;
    pp_t hh;
  } pp_set_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_ACK
  } ctrl_state_t;

endpackage

//--- verilog/mul_request_decode.sv
`timescale 1ns/100ps
`include "mul_defs.svh"

module mul_request_decode
  import mul_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          req,
  input  operand_pair_t operands,
  input  logic          done,
  output logic          ack,
  output logic          issue,
  output half_split_t   halves
);

  ctrl_state_t   state;
  logic          req_q;
  logic          start;
  operand_pair_t opnd_q;

  assign start = (state == ST_IDLE) && req_q;
  assign ack   = (state == ST_ACK);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= 1'b0;
      issue <= 1'b0;
      state <= ST_IDLE;
    end else begin
      req_q <= req;
      issue <= start;
      case (state)
        ST_IDLE: if (req_q) state <= ST_BUSY;
        ST_BUSY: if (done) state <= ST_ACK;
        ST_ACK:  if (!req_q) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Operands are stable while req is held
  always_ff @(posedge clk) begin
    if (start) begin
      opnd_q <= operands;
    end
  end

  always_comb begin
    halves.a_hi = opnd_q.a[`MUL_OPND_W-1:`MUL_HALF_W];
    halves.a_lo = opnd_q.a[`MUL_HALF_W-1:0];
    halves.b_hi = opnd_q.b[`MUL_OPND_W-1:`MUL_HALF_W];
    halves.b_lo = opnd_q.b[`MUL_HALF_W-1:0];
  end

  // One issue per request seen while idle
  assert property (@(posedge clk) disable iff (!rst_n)
    issue |-> $past(state == ST_IDLE) && $past(req, 2) && state == ST_BUSY);

  // Entering ST_ACK raises ack, so the request must still be up
  assert property (@(posedge clk) disable iff (!rst_n)
    (state == ST_BUSY && done) |-> req);

endmodule

//--- verilog/partial_product_stage.sv
`timescale 1ns/100ps

module partial_product_stage
  import mul_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        issue,
  input  half_split_t halves,
  output logic        pp_valid,
  output pp_set_t     pps
);

  pp_set_t pp_comb;

  array_mult8 lxl (
    .a (halves.a_lo),
    .b (halves.b_lo),
    .p (pp_comb.ll)
  );

  array_mult8 lxh (
    .a (halves.a_lo),
    .b (halves.b_hi),
    .p (pp_comb.lh)
  );

  array_mult8 hxl (
    .a (halves.a_hi),
    .b (halves.b_lo),
    .p (pp_comb.hl)
  );

  array_mult8 hxh (
    .a (halves.a_hi),
    .b (halves.b_hi),
    .p (pp_comb.hh)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pp_valid <= 1'b0;
    end else begin
      pp_valid <= issue;
    end
  end

  // All four products captured together
  always_ff @(posedge clk) begin
    if (issue) begin
      pps <= pp_comb;
    end
  end

endmodule

//--- verilog/product_result.sv
`timescale 1ns/100ps
`include "mul_defs.svh"

module product_result
  import mul_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    pp_valid,
  input  pp_set_t pps,
  output logic    done,
  output prod_t   product
);

  prod_t base_sum;
  prod_t lh_shift;
  prod_t hl_shift;
  prod_t mid_sum;
  prod_t total;

  // hh and ll never overlap, so they just concatenate
  assign base_sum = {pps.hh, pps.ll};

  // Cross terms sit one byte up
  assign lh_shift = {{`MUL_HALF_W{1'b0}}, pps.lh, {`MUL_HALF_W{1'b0}}};
  assign hl_shift = {{`MUL_HALF_W{1'b0}}, pps.hl, {`MUL_HALF_W{1'b0}}};

  cla_adder32 u_add_lh (
    .a   (base_sum),
    .b   (lh_shift),
    .sum (mid_sum)
  );

  cla_adder32 u_add_hl (
    .a   (mid_sum),
    .b   (hl_shift),
    .sum (total)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done    <= 1'b0;
      product <= '0;
    end else begin
      done <= pp_valid;
      if (pp_valid) begin
        product <= total;
      end
    end
  end

  // Result stage is a fixed single cycle and the adders match a plain sum
  assert property (@(posedge clk) disable iff (!rst_n)
    done == $past(pp_valid) &&
    (!done || product == $past(base_sum + lh_shift + hl_shift)));

endmodule
